// ==== blocking_cache.f ====
+incdir+.
blocking_cache_pkg.sv
cache_way.sv
cache_ctrl.sv
blocking_cache.sv
blocking_cache_assertions.sv
blocking_cache_tb.sv

// ==== blocking_cache.sv ====
// ------------------------------
// Two-way blocking write-back cache, top level
// ------------------------------

`default_nettype none

module blocking_cache (
  input  wire logic                                clk,
  input  wire logic                                reset,
  input  wire logic                                cachereq_val,
  output logic                                     cachereq_rdy,
  input  wire blocking_cache_pkg::cache_req_type_e cachereq_type,
  input  wire blocking_cache_pkg::addr_t           cachereq_addr,
  input  wire blocking_cache_pkg::word_t           cachereq_data,
  output logic                                     cacheresp_val,
  input  wire logic                                cacheresp_rdy,
  output blocking_cache_pkg::cache_req_type_e      cacheresp_type,
  output blocking_cache_pkg::word_t                cacheresp_data,
  output logic                                     memreq_val,
  input  wire logic                                memreq_rdy,
  output blocking_cache_pkg::mem_req_type_e        memreq_type,
  output blocking_cache_pkg::addr_t                memreq_addr,
  output blocking_cache_pkg::line_t                memreq_data,
  input  wire logic                                memresp_val,
  output logic                                     memresp_rdy,
  input  wire blocking_cache_pkg::line_t           memresp_data
);

  // Controller to ways
  blocking_cache_pkg::idx_t     idx;
  blocking_cache_pkg::tag_t     tag;
  blocking_cache_pkg::line_t    fill_line;
  blocking_cache_pkg::offset_t  word_offset;
  blocking_cache_pkg::word_t    word_data;
  logic                         mark_dirty;
  logic                         fill_en_0, fill_en_1, word_en_0, word_en_1;

  // Ways to controller
  logic                         match_0, match_1, valid_0, valid_1, dirty_0, dirty_1;
  blocking_cache_pkg::tag_t     stored_tag_0, stored_tag_1;
  blocking_cache_pkg::line_t    line_0, line_1;

  cache_way way0 (
    .clk, .reset, .idx, .tag,
    .match(match_0), .valid(valid_0), .dirty(dirty_0),
    .stored_tag(stored_tag_0), .line(line_0),
    .fill_en(fill_en_0), .fill_line,
    .word_en(word_en_0), .word_offset, .word_data, .mark_dirty
  );

  cache_way way1 (
    .clk, .reset, .idx, .tag,
    .match(match_1), .valid(valid_1), .dirty(dirty_1),
    .stored_tag(stored_tag_1), .line(line_1),
    .fill_en(fill_en_1), .fill_line,
    .word_en(word_en_1), .word_offset, .word_data, .mark_dirty
  );

  cache_ctrl ctrl0 (.*);

endmodule

`default_nettype wire

// ==== blocking_cache_assertions.sv ====
// ------------------------------
// Handshake and reset assertions, bound into the cache top level
// ------------------------------

`default_nettype none

module blocking_cache_assertions (
  input wire logic                                clk,
  input wire logic                                reset,
  input wire logic                                cachereq_val,
  input wire logic                                cachereq_rdy,
  input wire blocking_cache_pkg::cache_req_type_e cachereq_type,
  input wire blocking_cache_pkg::addr_t           cachereq_addr,
  input wire logic                                cacheresp_val,
  input wire logic                                cacheresp_rdy,
  input wire blocking_cache_pkg::cache_req_type_e cacheresp_type,
  input wire blocking_cache_pkg::word_t           cacheresp_data,
  input wire logic                                memreq_val,
  input wire logic                                memreq_rdy,
  input wire blocking_cache_pkg::mem_req_type_e   memreq_type,
  input wire blocking_cache_pkg::addr_t           memreq_addr,
  input wire logic                                memresp_val,
  input wire logic                                memresp_rdy,
  input wire blocking_cache_pkg::line_t           memresp_data
);

  // ------------------------------
  // Valid holds until the handshake
  // ------------------------------
  cachereq_hold: assert property (@(posedge clk) disable iff (reset)
    cachereq_val && !cachereq_rdy |=>
      cachereq_val && $stable(cachereq_addr) && $stable(cachereq_type))
    else $error("cache request dropped or changed before its handshake");

  cacheresp_hold: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=>
      cacheresp_val && $stable(cacheresp_data) && $stable(cacheresp_type))
    else $error("cache response dropped or changed before its handshake");

  memreq_hold: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=>
      memreq_val && $stable(memreq_addr) && $stable(memreq_type))
    else $error("memory request dropped or changed before its handshake");

  memresp_hold: assert property (@(posedge clk) disable iff (reset)
    memresp_val && !memresp_rdy |=> memresp_val && $stable(memresp_data))
    else $error("memory response dropped or changed before its handshake");

  // Idle outputs right after a reset edge
  reset_values: assert property (@(posedge clk)
    reset |=> cachereq_rdy && !cacheresp_val && !memreq_val && !memresp_rdy)
    else $error("handshake outputs not at their reset values");

endmodule

`default_nettype wire

// ==== blocking_cache_cases.txt ====
// Columns, all hex: type (0 READ, 1 WRITE, 2 WRITE_INIT), address, write data,
// expected response data, expected count of memory writes during the request
0 00000014 00000000 a5a50014 0  // cold read miss in set 1
1 00000018 deadbeef 00000000 0  // write hit, line turns dirty
0 00000018 00000000 deadbeef 0  // read back without memory traffic
0 00000090 00000000 a5a50090 0  // second tag fills the other way
0 00000110 00000000 a5a50110 1  // third tag evicts the dirty LRU line
0 00000018 00000000 deadbeef 0  // evicted data comes back from memory
2 00000024 12345678 00000000 0  // write-init allocates in set 2, clean
0 00000024 00000000 12345678 0  // read hit, no refill
0 000000a0 00000000 a5a500a0 0
0 00000120 00000000 a5a50120 0  // write-init line evicted without a write
0 00000024 00000000 a5a50024 0  // memory still holds the old word
1 00000034 cafef00d 00000000 0  // write miss refills first
0 00000034 00000000 cafef00d 0
1 000000b8 0badf00d 00000000 0
1 00000130 11112222 00000000 1  // dirty victim written back
0 000001b4 00000000 a5a501b4 1
0 000000b8 00000000 0badf00d 1
0 00000034 00000000 cafef00d 0  // clean victim, data from earlier eviction

// ==== blocking_cache_config.svh ====
// ------------------------------
// Size and address-field macros for the two-way blocking cache
// Included by the package and by the RTL modules that slice addresses
// ------------------------------

`ifndef BLOCKING_CACHE_CONFIG_SVH
`define BLOCKING_CACHE_CONFIG_SVH

// Bus widths
`define CACHE_ADDR_W      32
`define CACHE_WORD_W      32

// Geometry, per way
`define CACHE_LINE_WORDS  4
`define CACHE_SETS        8

// Address fields
// Byte offset sits below the word offset
`define CACHE_OFFSET_LSB  2
`define CACHE_OFFSET_W    2
`define CACHE_IDX_LSB     4
`define CACHE_IDX_W       3

// Tag is everything above the index
`define CACHE_TAG_LSB     7

`endif

// ==== blocking_cache_pkg.sv ====
// ------------------------------
// Shared types for the blocking cache: address fields, data, opcodes
// and controller states
// ------------------------------

`default_nettype none

`include "blocking_cache_config.svh"

package blocking_cache_pkg;

  // Address and its fields
  typedef logic [`CACHE_ADDR_W-1:0]                  addr_t;
  typedef logic [`CACHE_ADDR_W-`CACHE_TAG_LSB-1:0]   tag_t;
  typedef logic [`CACHE_IDX_W-1:0]                   idx_t;
  typedef logic [`CACHE_OFFSET_W-1:0]                offset_t;

  // Data, word 0 in the low bits of a line
  typedef logic [`CACHE_WORD_W-1:0]                          word_t;
  typedef logic [`CACHE_LINE_WORDS-1:0][`CACHE_WORD_W-1:0]   line_t;

  // ------------------------------
  // Opcodes
  // ------------------------------
  typedef enum logic [1:0] {READ = 2'd0, WRITE = 2'd1, WRITE_INIT = 2'd2} cache_req_type_e;

  typedef enum logic [0:0] {MEM_READ = 1'b0, MEM_WRITE = 1'b1} mem_req_type_e;

  // Controller FSM
  typedef enum logic [3:0] {
    IDLE, TAG_CHECK, READ_ACCESS, WRITE_ACCESS, REFILL_REQUEST, REFILL_WAIT,
    REFILL_UPDATE, EVICT_PREPARE, EVICT_REQUEST, EVICT_WAIT, WAIT
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== blocking_cache_tb.sv ====
// ------------------------------
// Testbench for the blocking cache: requests and expected results come
// from the cases file, memory is modelled here with random stalls
// ------------------------------

`default_nettype none

`include "blocking_cache_config.svh"

module blocking_cache_tb;

  localparam int MAX_CASES   = 32;
  localparam int CASE_FIELDS = 5;

  logic                                 clk;
  logic                                 reset;
  logic                                 cachereq_val;
  logic                                 cachereq_rdy;
  blocking_cache_pkg::cache_req_type_e  cachereq_type;
  blocking_cache_pkg::addr_t            cachereq_addr;
  blocking_cache_pkg::word_t            cachereq_data;
  logic                                 cacheresp_val;
  logic                                 cacheresp_rdy;
  blocking_cache_pkg::cache_req_type_e  cacheresp_type;
  blocking_cache_pkg::word_t            cacheresp_data;
  logic                                 memreq_val;
  logic                                 memreq_rdy;
  blocking_cache_pkg::mem_req_type_e    memreq_type;
  blocking_cache_pkg::addr_t            memreq_addr;
  blocking_cache_pkg::line_t            memreq_data;
  logic                                 memresp_val;
  logic                                 memresp_rdy;
  blocking_cache_pkg::line_t            memresp_data;

  logic [31:0]                          case_mem [0:MAX_CASES*CASE_FIELDS-1];
  int                                   num_cases = 0;
  int                                   cycles = 0;
  int                                   cycle_limit = 0;
  integer                               seed = 74;

  // Memory model state
  blocking_cache_pkg::word_t            mem [blocking_cache_pkg::addr_t];
  int                                   mem_write_total = 0;
  blocking_cache_pkg::mem_req_type_e    seen_type;
  blocking_cache_pkg::addr_t            seen_addr;
  blocking_cache_pkg::line_t            seen_line;

  blocking_cache dut0 (.*);

  bind blocking_cache blocking_cache_assertions asrt0 (
    .clk, .reset,
    .cachereq_val, .cachereq_rdy, .cachereq_type, .cachereq_addr,
    .cacheresp_val, .cacheresp_rdy, .cacheresp_type, .cacheresp_data,
    .memreq_val, .memreq_rdy, .memreq_type, .memreq_addr,
    .memresp_val, .memresp_rdy, .memresp_data
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic report_failure();
    $display("TB FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_word(input int n, input blocking_cache_pkg::word_t expected,
                            input blocking_cache_pkg::word_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED case %0d response data: expected %h, actual %h",
               n, expected, actual);
      report_failure();
    end
  endtask

  task automatic check_type(input int n, input blocking_cache_pkg::cache_req_type_e expected,
                            input blocking_cache_pkg::cache_req_type_e actual);
    if (actual !== expected) begin
      $display("CHECK FAILED case %0d response type: expected %s, actual %s",
               n, expected.name(), actual.name());
      report_failure();
    end
  endtask

  task automatic check_count(input int n, input int expected, input int actual);
    if (actual != expected) begin
      $display("CHECK FAILED case %0d memory writes: expected %0d, actual %0d",
               n, expected, actual);
      report_failure();
    end
  endtask

  // 0 to 3 idle cycles
  function automatic int next_stall();
    return $unsigned($random(seed)) % 4;
  endfunction

  // Untouched memory reads back as its address with a fixed pattern
  function automatic blocking_cache_pkg::line_t load_line(input blocking_cache_pkg::addr_t base);
    blocking_cache_pkg::line_t  data;
    blocking_cache_pkg::addr_t  a;
    for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
      a = base + 32'(4 * w);
      data[w] = mem.exists(a) ? mem[a] : (a ^ 32'hA5A5_0000);
    end
    return data;
  endfunction

  function automatic void store_line(input blocking_cache_pkg::addr_t base,
                                     input blocking_cache_pkg::line_t data);
    for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
      mem[base + 32'(4 * w)] = data[w];
    end
  endfunction

  // ------------------------------
  // Memory side
  // ------------------------------
  initial begin
    memreq_rdy   = 1'b0;
    memresp_val  = 1'b0;
    memresp_data = '0;
    forever begin
      @(negedge clk);
      if (!reset && memreq_val) begin
        repeat (next_stall()) @(negedge clk);
        memreq_rdy = 1'b1;
        seen_type  = memreq_type;
        seen_addr  = memreq_addr;
        seen_line  = memreq_data;
        @(negedge clk);
        memreq_rdy = 1'b0;
        if (seen_type == blocking_cache_pkg::MEM_WRITE) begin
          store_line(seen_addr, seen_line);
          mem_write_total++;
          memresp_data = '0;
        end else begin
          memresp_data = load_line(seen_addr);
        end
        // Write ack or read data
        repeat (next_stall()) @(negedge clk);
        memresp_val = 1'b1;
        while (!memresp_rdy) @(negedge clk);
        @(negedge clk);
        memresp_val = 1'b0;
      end
    end
  end

  // One request from the cases file, through to its response
  task automatic run_case(input int n);
    blocking_cache_pkg::cache_req_type_e  req_type;
    int                                   exp_writes;
    int                                   writes_before;
    blocking_cache_pkg::word_t            exp_data;
    req_type      = blocking_cache_pkg::cache_req_type_e'(case_mem[n * CASE_FIELDS][1:0]);
    exp_data      = case_mem[n * CASE_FIELDS + 3];
    exp_writes    = int'(case_mem[n * CASE_FIELDS + 4]);
    writes_before = mem_write_total;
    cachereq_val  = 1'b1;
    cachereq_type = req_type;
    cachereq_addr = case_mem[n * CASE_FIELDS + 1];
    cachereq_data = case_mem[n * CASE_FIELDS + 2];
    while (!cachereq_rdy) @(negedge clk);
    @(negedge clk);
    cachereq_val = 1'b0;
    while (!cacheresp_val) @(negedge clk);
    repeat (next_stall()) @(negedge clk);
    cacheresp_rdy = 1'b1;
    check_type(n, req_type, cacheresp_type);
    check_word(n, exp_data, cacheresp_data);
    @(negedge clk);
    cacheresp_rdy = 1'b0;
    check_count(n, exp_writes, mem_write_total - writes_before);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, a request never completed", cycles);
      report_failure();
    end
  end

  initial begin
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_type = blocking_cache_pkg::READ;
    cachereq_addr = '0;
    cachereq_data = '0;
    cacheresp_rdy = 1'b0;
    for (int i = 0; i < MAX_CASES * CASE_FIELDS; i++) begin
      case_mem[i] = '1;
    end
    $readmemh("blocking_cache_cases.txt", case_mem);
    while (num_cases < MAX_CASES && case_mem[num_cases * CASE_FIELDS] != 32'hFFFF_FFFF) begin
      num_cases++;
    end
    if (num_cases == 0) begin
      $display("No requests found in the cases file");
      report_failure();
    end
    cycle_limit = 60 * num_cases + 10;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    for (int n = 0; n < num_cases; n++) begin
      run_case(n);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== cache_ctrl.sv ====
// ------------------------------
// Cache controller: request latch, FSM, per-set LRU and way choice
// Drives both ways and builds the memory-side requests
// ------------------------------

`default_nettype none

`include "blocking_cache_config.svh"

module cache_ctrl (
  input  wire logic                                clk,
  input  wire logic                                reset,
  input  wire logic                                cachereq_val,
  output logic                                     cachereq_rdy,
  input  wire blocking_cache_pkg::cache_req_type_e cachereq_type,
  input  wire blocking_cache_pkg::addr_t           cachereq_addr,
  input  wire blocking_cache_pkg::word_t           cachereq_data,
  output logic                                     cacheresp_val,
  input  wire logic                                cacheresp_rdy,
  output blocking_cache_pkg::cache_req_type_e      cacheresp_type,
  output blocking_cache_pkg::word_t                cacheresp_data,
  output logic                                     memreq_val,
  input  wire logic                                memreq_rdy,
  output blocking_cache_pkg::mem_req_type_e        memreq_type,
  output blocking_cache_pkg::addr_t                memreq_addr,
  output blocking_cache_pkg::line_t                memreq_data,
  input  wire logic                                memresp_val,
  output logic                                     memresp_rdy,
  input  wire blocking_cache_pkg::line_t           memresp_data,
  // Way interface
  output blocking_cache_pkg::idx_t                 idx,
  output blocking_cache_pkg::tag_t                 tag,
  input  wire logic                                match_0,
  input  wire logic                                match_1,
  input  wire logic                                valid_0,
  input  wire logic                                valid_1,
  input  wire logic                                dirty_0,
  input  wire logic                                dirty_1,
  input  wire blocking_cache_pkg::tag_t            stored_tag_0,
  input  wire blocking_cache_pkg::tag_t            stored_tag_1,
  input  wire blocking_cache_pkg::line_t           line_0,
  input  wire blocking_cache_pkg::line_t           line_1,
  output logic                                     fill_en_0,
  output logic                                     fill_en_1,
  output logic                                     word_en_0,
  output logic                                     word_en_1,
  output blocking_cache_pkg::line_t                fill_line,
  output blocking_cache_pkg::offset_t              word_offset,
  output blocking_cache_pkg::word_t                word_data,
  output logic                                     mark_dirty
);

  blocking_cache_pkg::ctrl_state_e      state_q, state_d;
  blocking_cache_pkg::cache_req_type_e  req_type_q;
  blocking_cache_pkg::addr_t            req_addr_q;
  blocking_cache_pkg::word_t            req_data_q;
  blocking_cache_pkg::word_t            resp_word_q;
  blocking_cache_pkg::line_t            line_buf_q;
  blocking_cache_pkg::tag_t             evict_tag_q;
  blocking_cache_pkg::line_t            way_line;
  logic [`CACHE_SETS-1:0]               lru_q;
  logic                                 way_q;
  logic                                 way_pick;
  logic                                 hit;
  logic                                 victim_dirty;

  assign idx         = req_addr_q[`CACHE_IDX_LSB +: `CACHE_IDX_W];
  assign tag         = req_addr_q[`CACHE_ADDR_W-1:`CACHE_TAG_LSB];
  assign word_offset = req_addr_q[`CACHE_OFFSET_LSB +: `CACHE_OFFSET_W];

  // Hit way wins, otherwise the LRU way of the set is the victim
  assign hit          = match_0 || match_1;
  assign way_pick     = hit ? match_1 : lru_q[idx];
  assign victim_dirty = way_pick ? (valid_1 && dirty_1) : (valid_0 && dirty_0);
  assign way_line     = way_q ? line_1 : line_0;

  // ------------------------------
  // FSM
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      blocking_cache_pkg::IDLE:
        if (cachereq_val) state_d = blocking_cache_pkg::TAG_CHECK;
      blocking_cache_pkg::TAG_CHECK:
        if (req_type_q == blocking_cache_pkg::WRITE_INIT) state_d = blocking_cache_pkg::WRITE_ACCESS;
        else if (hit && req_type_q == blocking_cache_pkg::READ) state_d = blocking_cache_pkg::READ_ACCESS;
        else if (hit) state_d = blocking_cache_pkg::WRITE_ACCESS;
        else if (!victim_dirty) state_d = blocking_cache_pkg::REFILL_REQUEST;
        else state_d = blocking_cache_pkg::EVICT_PREPARE;
      blocking_cache_pkg::READ_ACCESS, blocking_cache_pkg::WRITE_ACCESS:
        state_d = blocking_cache_pkg::WAIT;
      blocking_cache_pkg::REFILL_REQUEST:
        if (memreq_rdy) state_d = blocking_cache_pkg::REFILL_WAIT;
      blocking_cache_pkg::REFILL_WAIT:
        if (memresp_val) state_d = blocking_cache_pkg::REFILL_UPDATE;
      blocking_cache_pkg::REFILL_UPDATE:
        if (req_type_q == blocking_cache_pkg::READ) state_d = blocking_cache_pkg::READ_ACCESS;
        else state_d = blocking_cache_pkg::WRITE_ACCESS;
      blocking_cache_pkg::EVICT_PREPARE:
        state_d = blocking_cache_pkg::EVICT_REQUEST;
      blocking_cache_pkg::EVICT_REQUEST:
        if (memreq_rdy) state_d = blocking_cache_pkg::EVICT_WAIT;
      // Write ack received, go fetch the new line
      blocking_cache_pkg::EVICT_WAIT:
        if (memresp_val) state_d = blocking_cache_pkg::REFILL_REQUEST;
      blocking_cache_pkg::WAIT:
        if (cacheresp_rdy) state_d = blocking_cache_pkg::IDLE;
      default:
        state_d = blocking_cache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= blocking_cache_pkg::IDLE;
      way_q   <= 1'b0;
      lru_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == blocking_cache_pkg::TAG_CHECK) way_q <= way_pick;
      // Accessed way becomes MRU, the other one is next victim
      if (state_q == blocking_cache_pkg::READ_ACCESS ||
          state_q == blocking_cache_pkg::WRITE_ACCESS) begin
        lru_q[idx] <= ~way_q;
      end
    end
  end

  // ------------------------------
  // Request, response and line buffers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (cachereq_val && cachereq_rdy) begin
      req_type_q <= cachereq_type;
      req_addr_q <= cachereq_addr;
      req_data_q <= cachereq_data;
    end
    if (state_q == blocking_cache_pkg::READ_ACCESS) resp_word_q <= way_line[word_offset];
    // Victim snapshot, the buffer is reused for the refill line
    if (state_q == blocking_cache_pkg::EVICT_PREPARE) begin
      evict_tag_q <= way_q ? stored_tag_1 : stored_tag_0;
      line_buf_q  <= way_line;
    end
    if (state_q == blocking_cache_pkg::REFILL_WAIT && memresp_val) line_buf_q <= memresp_data;
  end

  // Handshake outputs straight from the state
  assign cachereq_rdy  = (state_q == blocking_cache_pkg::IDLE);
  assign cacheresp_val = (state_q == blocking_cache_pkg::WAIT);
  assign memreq_val    = (state_q == blocking_cache_pkg::REFILL_REQUEST) ||
                         (state_q == blocking_cache_pkg::EVICT_REQUEST);
  assign memresp_rdy   = (state_q == blocking_cache_pkg::REFILL_WAIT) ||
                         (state_q == blocking_cache_pkg::EVICT_WAIT);

  assign cacheresp_type = req_type_q;
  assign cacheresp_data = (req_type_q == blocking_cache_pkg::READ) ? resp_word_q : '0;

  // Line-aligned memory requests, eviction uses the victim tag
  always_comb begin
    if (state_q == blocking_cache_pkg::EVICT_REQUEST) begin
      memreq_type = blocking_cache_pkg::MEM_WRITE;
      memreq_addr = {evict_tag_q, idx, {`CACHE_IDX_LSB{1'b0}}};
      memreq_data = line_buf_q;
    end else begin
      memreq_type = blocking_cache_pkg::MEM_READ;
      memreq_addr = {tag, idx, {`CACHE_IDX_LSB{1'b0}}};
      memreq_data = '0;
    end
  end

  // Way write strobes
  assign fill_en_0  = (state_q == blocking_cache_pkg::REFILL_UPDATE) && !way_q;
  assign fill_en_1  = (state_q == blocking_cache_pkg::REFILL_UPDATE) && way_q;
  assign word_en_0  = (state_q == blocking_cache_pkg::WRITE_ACCESS) && !way_q;
  assign word_en_1  = (state_q == blocking_cache_pkg::WRITE_ACCESS) && way_q;
  assign fill_line  = line_buf_q;
  assign word_data  = req_data_q;
  // Write-init allocates without making the line dirty
  assign mark_dirty = (req_type_q != blocking_cache_pkg::WRITE_INIT);

endmodule

`default_nettype wire

// ==== cache_way.sv ====
// ------------------------------
// One way of the cache: valid, dirty and tag bits plus line storage
// Reads of the addressed set are combinational, writes land at the edge
// ------------------------------

`default_nettype none

`include "blocking_cache_config.svh"

module cache_way (
  input  wire logic                      clk,
  input  wire logic                      reset,

  // Set lookup
  input  wire blocking_cache_pkg::idx_t  idx,
  input  wire blocking_cache_pkg::tag_t  tag,
  output logic                           match,
  output logic                           valid,
  output logic                           dirty,
  output blocking_cache_pkg::tag_t       stored_tag,
  output blocking_cache_pkg::line_t      line,

  // Whole-line fill from memory
  input  wire logic                      fill_en,
  input  wire blocking_cache_pkg::line_t fill_line,

  // Single word write from the processor side
  input  wire logic                         word_en,
  input  wire blocking_cache_pkg::offset_t  word_offset,
  input  wire blocking_cache_pkg::word_t    word_data,
  input  wire logic                         mark_dirty
);

  logic [`CACHE_SETS-1:0]     valid_q;
  logic [`CACHE_SETS-1:0]     dirty_q;
  blocking_cache_pkg::tag_t   tag_q  [`CACHE_SETS];
  blocking_cache_pkg::line_t  line_q [`CACHE_SETS];

  // Lookup of the addressed set
  assign valid      = valid_q[idx];
  assign dirty      = dirty_q[idx];
  assign stored_tag = tag_q[idx];
  assign line       = line_q[idx];
  assign match      = valid && (stored_tag == tag);

  // ------------------------------
  // Status bits
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill_en) begin
      valid_q[idx] <= 1'b1;
      // Fresh line from memory is clean
      dirty_q[idx] <= 1'b0;
    end else if (word_en) begin
      valid_q[idx] <= 1'b1;
      dirty_q[idx] <= mark_dirty;
    end
  end

  // ------------------------------
  // Tag and line storage
  // ------------------------------
  always_ff @(posedge clk) begin
    if (fill_en) begin
      tag_q[idx]  <= tag;
      line_q[idx] <= fill_line;
    end else if (word_en) begin
      tag_q[idx]               <= tag;
      line_q[idx][word_offset] <= word_data;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the blocking cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f blocking_cache.f \
  --top-module blocking_cache_tb -o blocking_cache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/blocking_cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit 1
fi
exit 0
